// File: filelist.f
verilog/noc_pkg.sv
verilog/ni_fifo.sv
verilog/ni.sv
verilog/cluster_router.sv
verilog/gpu_cluster.sv
tb/tb_gpu_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_gpu_cluster -Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit $sim_status
fi
exit 0

// File: tb/cluster_patterns.txt
# mode src in_flit port exp_flit, flits in hex, header in the upper 6 bits
# src 0-3 leaf, 4 uplink; port 0-3 GPU leaf, 4 uplink, 9 no output
1 0 2841 1 2841
1 0 2c42 2 2c42
1 0 3043 3 3043
1 0 2844 1 2844
1 3 2446 0 2446
2 0 0481 4 1081
2 1 7882 4 8482
2 2 2083 4 2c83
2 3 3484 4 4084
3 4 30c1 0 24c1
3 4 34c2 1 28c2
3 4 38c3 2 2cc3
3 4 3cc4 3 30c4
3 4 2cc5 9 0000
3 4 40c6 9 0000
4 0 2901 1 2901
4 0 0503 4 1103
4 1 2504 0 2504
4 1 3105 3 3105
4 2 3107 3 3107
4 2 2508 0 2508
4 3 2d0a 2 2d0a
4 3 250c 0 250c
4 4 310d 0 250d
4 4 3d0e 3 310e
5 1 2541 0 2541
5 1 3142 3 3142
5 1 7943 4 8543
5 1 2d44 2 2d44
6 4 3181 0 2581
6 4 3182 0 2582
6 4 3183 0 2583
6 4 3184 0 2584
6 4 3185 9 0000
6 4 3186 9 0000
6 4 3187 9 0000
6 4 3188 9 0000

// File: tb/tb_gpu_cluster.sv
`timescale 1ns/1ps

module tb_gpu_cluster;
    import noc_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_LINE = 200;
    localparam int UPLINK_SRC      = 4;
    localparam int UPLINK_PORT     = 4;
    localparam int NO_PORT         = 9;
    localparam int STALL_LEAF      = 0;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    flit_t [NUM_LEAVES-1:0] gpu_data_in = '0;
    logic [NUM_LEAVES-1:0]  gpu_valid_in = '0;
    logic [NUM_LEAVES-1:0]  gpu_ready_in = '1;
    flit_t                  uplink_data_in = '0;
    logic                   uplink_valid_in = 1'b0;
    logic                   uplink_ready_in = 1'b1;
    logic [NUM_LEAVES-1:0]  gpu_ready_out;
    flit_t [NUM_LEAVES-1:0] gpu_data_out;
    logic [NUM_LEAVES-1:0]  gpu_valid_out;
    flit_t                  uplink_data_out;
    logic                   uplink_valid_out;

    int    line_mode [$];
    int    line_src [$];
    flit_t line_in [$];
    int    line_port [$];
    flit_t line_exp [$];

    // Outstanding flits per output with ports 0-3 for the GPUs and 4 for the uplink
    flit_t exp_q [UPLINK_PORT+1][$];
    int    exp_src [UPLINK_PORT+1][$];
    logic                  stall_rand = 1'b0;
    logic [NUM_LEAVES-1:0] hold_mask = '0;
    int                    stall_seen = 0;

    gpu_cluster DUT (
        .clk              (clk),
        .reset            (reset),
        .gpu_data_in      (gpu_data_in),
        .gpu_valid_in     (gpu_valid_in),
        .gpu_ready_in     (gpu_ready_in),
        .uplink_data_in   (uplink_data_in),
        .uplink_valid_in  (uplink_valid_in),
        .uplink_ready_in  (uplink_ready_in),
        .gpu_ready_out    (gpu_ready_out),
        .gpu_data_out     (gpu_data_out),
        .gpu_valid_out    (gpu_valid_out),
        .uplink_data_out  (uplink_data_out),
        .uplink_valid_out (uplink_valid_out)
    );

    always #2 clk = ~clk;

    // GPU side receive stalls
    always @(negedge clk) begin
        if (stall_rand) begin
            gpu_ready_in <= NUM_LEAVES'($urandom) | NUM_LEAVES'($urandom);
        end else begin
            gpu_ready_in <= ~hold_mask;
        end
    end

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_flit(input flit_t got, input flit_t exp, input string what);
        if (got !== exp) begin
            $display("ERR at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    mode;
        int    src;
        int    port;
        flit_t in_flit;
        flit_t exp_flit;
        string text;
        fd = $fopen("tb/cluster_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file tb/cluster_patterns.txt");
            stop_with_failure();
        end else begin
            // Comment lines do not parse and are skipped
            while ($fgets(text, fd) > 0) begin
                if ($sscanf(text, "%d %d %h %d %h", mode, src, in_flit, port, exp_flit) == 5) begin
                    line_mode.push_back(mode);
                    line_src.push_back(src);
                    line_in.push_back(in_flit);
                    line_port.push_back(port);
                    line_exp.push_back(exp_flit);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic cross_check_line(input int i);
        route_addr_t addr;
        gpu_id_t     id;
        int          port;
        flit_t       flit;
        if (line_src[i] == UPLINK_SRC) begin
            addr = line_in[i][FLIT_W-1 -: HDR_W];
            id   = gpu_id_t'(int'(addr) - ADDR_OFFSET);
        end else begin
            id   = line_in[i][FLIT_W-1 -: HDR_W];
            addr = route_addr_t'(int'(id) + ADDR_OFFSET);
        end
        flit = {id, line_in[i][PAYLOAD_W-1:0]};
        port = int'(addr[LEAF_W-1:0]);
        if (addr[HDR_W-1 -: GROUP_W] != CLUSTER_GROUP) begin
            port = (line_src[i] == UPLINK_SRC) ? NO_PORT : UPLINK_PORT;
            flit = {addr, line_in[i][PAYLOAD_W-1:0]};
        end
        // Stalled GPU keeps one queue of flits and loses later ones
        if (line_mode[i] == 6 && port == STALL_LEAF) begin
            if (stall_seen >= NI_FIFO_DEPTH) begin
                port = NO_PORT;
            end
            stall_seen++;
        end
        check_flit(flit_t'(line_port[i]), flit_t'(port), $sformatf("pattern %0d port", i));
        if (port != NO_PORT) begin
            check_flit(line_exp[i], flit, $sformatf("pattern %0d flit", i));
        end
    endtask

    task automatic expect_line(input int i);
        if (line_port[i] != NO_PORT) begin
            exp_q[line_port[i]].push_back(line_exp[i]);
            exp_src[line_port[i]].push_back(line_src[i]);
        end
    endtask

    task automatic match_output(input int port, input flit_t got);
        int hit;
        int first;
        hit   = -1;
        first = -1;
        if (exp_q[port].size() == 0) begin
            $display("Flit %h came out of port %0d with nothing expected there", got, port);
            stop_with_failure();
        end else begin
            for (int k = 0; k < exp_q[port].size(); k++) begin
                if (hit < 0 && exp_q[port][k] == got) begin
                    hit = k;
                end
            end
            if (hit < 0) begin
                check_flit(got, exp_q[port][0], $sformatf("flit on port %0d", port));
            end else begin
                // Oldest outstanding flit of the same source has to come first
                for (int k = hit; k >= 0; k--) begin
                    if (exp_src[port][k] == exp_src[port][hit]) begin
                        first = k;
                    end
                end
                check_flit(got, exp_q[port][first], $sformatf("order on port %0d", port));
                exp_q[port].delete(hit);
                exp_src[port].delete(hit);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < NUM_LEAVES; p++) begin
                if (gpu_valid_out[p]) begin
                    match_output(p, gpu_data_out[p]);
                end
            end
            if (uplink_valid_out) begin
                match_output(UPLINK_PORT, uplink_data_out);
            end
        end
    end

    function automatic int pending_count();
        int n;
        n = 0;
        for (int p = 0; p <= UPLINK_PORT; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic wait_drain();
        while (pending_count() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) @(negedge clk);
    endtask

    task automatic send_line(input int i);
        int leaf;
        leaf = line_src[i];
        @(negedge clk);
        if (leaf == UPLINK_SRC) begin
            uplink_data_in  = line_in[i];
            uplink_valid_in = 1'b1;
            @(negedge clk);
            uplink_valid_in = 1'b0;
        end else begin
            gpu_data_in[leaf]  = line_in[i];
            gpu_valid_in[leaf] = 1'b1;
            // Held until the NI has room and written on the next rising edge
            while (!gpu_ready_out[leaf]) begin
                @(negedge clk);
            end
            @(negedge clk);
            gpu_valid_in[leaf] = 1'b0;
        end
    endtask

    task automatic drive_source(input int m, input int s);
        for (int i = 0; i < line_mode.size(); i++) begin
            if (line_mode[i] == m && line_src[i] == s) begin
                send_line(i);
                idle_gap();
            end
        end
    endtask

    task automatic run_mode(input int m);
        int leaf;
        leaf = 0;
        if (m == 4) begin
            for (int i = 0; i < line_mode.size(); i++) begin
                if (line_mode[i] == m) begin
                    expect_line(i);
                end
            end
            fork
                drive_source(m, 0);
                drive_source(m, 1);
                drive_source(m, 2);
                drive_source(m, 3);
                drive_source(m, UPLINK_SRC);
            join
        end else begin
            @(negedge clk);
            stall_rand      = (m <= 3);
            uplink_ready_in = (m != 5);
            hold_mask       = (m == 6) ? NUM_LEAVES'(1) << STALL_LEAF : '0;
            @(negedge clk);
            for (int i = 0; i < line_mode.size(); i++) begin
                if (line_mode[i] == m) begin
                    expect_line(i);
                    send_line(i);
                    leaf = line_src[i];
                    if (m <= 3) begin
                        // Mode 1 keeps several flits of one source in flight at once
                        if (m != 1) begin
                            wait_drain();
                        end
                        idle_gap();
                    end
                end
            end
            if (m == 5) begin
                check_flit(flit_t'(gpu_ready_out[leaf]), '0, "gpu_ready_out on a full queue");
            end
            // Last uplink flit reaches the receive queue one edge after its strobe
            repeat (2) @(negedge clk);
            stall_rand      = 1'b0;
            uplink_ready_in = 1'b1;
            hold_mask       = '0;
        end
        wait_drain();
    endtask

    task automatic run_watchdog();
        repeat (line_mode.size() * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk);
        $display("Timeout, the DUT stopped delivering the expected flits");
        stop_with_failure();
    endtask

    initial begin
        void'($urandom(32'hc4459574));
        load_patterns();
        for (int i = 0; i < line_mode.size(); i++) begin
            cross_check_line(i);
        end
        fork
            run_watchdog();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int m = 1; m <= 6; m++) begin
            run_mode(m);
        end
        // Quiet time to catch stray deliveries
        repeat (20) @(negedge clk);
        if (pending_count() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d expected flits never came out", pending_count());
            stop_with_failure();
        end
    end

endmodule

// File: verilog/cluster_router.sv
`timescale 1ns/1ps

module cluster_router (
    input  logic                                      clk,
    input  logic                                      reset,
    input  noc_pkg::flit_t [noc_pkg::NUM_LEAVES-1:0] ni_data,
    input  logic [noc_pkg::NUM_LEAVES-1:0]           ni_valid,
    input  noc_pkg::flit_t                            uplink_data_in,
    input  logic                                      uplink_valid_in,
    input  logic                                      uplink_ready_in,
    output logic [noc_pkg::NUM_LEAVES-1:0]           grant,
    output noc_pkg::flit_t                            bus_data,
    output logic                                      bus_valid,
    output noc_pkg::flit_t                            uplink_data_out,
    output logic                                      uplink_valid_out
);
    import noc_pkg::*;

    logic  running;
    leaf_t rr_last;
    leaf_t rr_next;
    flit_t ni_flit;
    logic  ni_any;
    flit_t pend_data;
    logic  pend_valid;
    flit_t local_flit;
    logic  local_valid;
    logic  local_go;
    logic  egress;

    // Round robin is skipped entirely while the uplink owns the bus
    assign rr_next = rr_last + 1'b1;
    assign grant   = (running && uplink_ready_in && !uplink_valid_in) ?
                     (NUM_LEAVES'(1) << rr_next) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            rr_last <= leaf_t'(NUM_LEAVES - 1);
        end else begin
            running <= 1'b1;
            if (|grant) begin
                rr_last <= rr_next;
            end
        end
    end

    // At most one leaf is valid, so an OR is enough to select it
    always_comb begin
        ni_flit = '0;
        for (int i = 0; i < NUM_LEAVES; i++) begin
            if (ni_valid[i]) begin
                ni_flit = ni_flit | ni_data[i];
            end
        end
    end

    assign ni_any = |ni_valid;

    // An NI flit that meets an uplink flit waits one slot in pend_data
    assign local_valid = pend_valid || ni_any;
    assign local_flit  = pend_valid ? pend_data : ni_flit;
    assign local_go    = local_valid && !uplink_valid_in;
    assign egress      = local_go && (addr_group(flit_hdr(local_flit)) != CLUSTER_GROUP);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_valid        <= 1'b0;
            uplink_valid_out <= 1'b0;
            pend_valid       <= 1'b0;
        end else begin
            bus_valid        <= uplink_valid_in || local_valid;
            uplink_valid_out <= egress;
            pend_valid       <= uplink_valid_in && local_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uplink_valid_in) begin
            bus_data  <= uplink_data_in;
            pend_data <= local_flit;
        end else if (local_valid) begin
            bus_data <= local_flit;
        end
        if (egress) begin
            uplink_data_out <= local_flit;
        end
    end

    a_one_ni_valid: assert property (@(posedge clk) disable iff (reset) $onehot0(ni_valid));

    // No grant is given on an uplink cycle, so a held flit never meets a new one
    a_pend_alone: assert property (@(posedge clk) disable iff (reset)
        !(pend_valid && ni_any));

endmodule

// File: verilog/gpu_cluster.sv
`timescale 1ns/1ps

module gpu_cluster (
    input  logic                                      clk,
    input  logic                                      reset,
    input  noc_pkg::flit_t [noc_pkg::NUM_LEAVES-1:0] gpu_data_in,
    input  logic [noc_pkg::NUM_LEAVES-1:0]           gpu_valid_in,
    input  logic [noc_pkg::NUM_LEAVES-1:0]           gpu_ready_in,
    input  noc_pkg::flit_t                            uplink_data_in,
    input  logic                                      uplink_valid_in,
    input  logic                                      uplink_ready_in,
    output logic [noc_pkg::NUM_LEAVES-1:0]           gpu_ready_out,
    output noc_pkg::flit_t [noc_pkg::NUM_LEAVES-1:0] gpu_data_out,
    output logic [noc_pkg::NUM_LEAVES-1:0]           gpu_valid_out,
    output noc_pkg::flit_t                            uplink_data_out,
    output logic                                      uplink_valid_out
);
    import noc_pkg::*;

    flit_t [NUM_LEAVES-1:0] ni_data;
    logic  [NUM_LEAVES-1:0] ni_valid;
    logic  [NUM_LEAVES-1:0] grant;
    flit_t                  bus_data;
    logic                   bus_valid;

    // Leaf g serves GPU 4*group - 3 + g, which is 9 to 12 for group 3
    for (genvar g = 0; g < NUM_LEAVES; g++) begin : g_leaf
        ni #(
            .GPU_ID (gpu_id_t'(CLUSTER_GROUP * NUM_LEAVES - ADDR_OFFSET + g))
        ) u_ni (
            .clk              (clk),
            .reset            (reset),
            .gpu_data_in      (gpu_data_in[g]),
            .gpu_valid_in     (gpu_valid_in[g]),
            .gpu_ready_in     (gpu_ready_in[g]),
            .router_ready_in  (grant[g]),
            .router_data_in   (bus_data),
            .router_valid_in  (bus_valid),
            .gpu_ready_out    (gpu_ready_out[g]),
            .gpu_data_out     (gpu_data_out[g]),
            .gpu_valid_out    (gpu_valid_out[g]),
            .router_data_out  (ni_data[g]),
            .router_valid_out (ni_valid[g])
        );
    end

    // Broadcast bus goes back to every NI
    cluster_router u_router (
        .clk              (clk),
        .reset            (reset),
        .ni_data          (ni_data),
        .ni_valid         (ni_valid),
        .uplink_data_in   (uplink_data_in),
        .uplink_valid_in  (uplink_valid_in),
        .uplink_ready_in  (uplink_ready_in),
        .grant            (grant),
        .bus_data         (bus_data),
        .bus_valid        (bus_valid),
        .uplink_data_out  (uplink_data_out),
        .uplink_valid_out (uplink_valid_out)
    );

endmodule

// File: verilog/ni.sv
`timescale 1ns/1ps

module ni #(
    parameter noc_pkg::gpu_id_t GPU_ID = 6'd9
) (
    input  logic           clk,
    input  logic           reset,
    input  noc_pkg::flit_t gpu_data_in,
    input  logic           gpu_valid_in,
    input  logic           gpu_ready_in,
    input  logic           router_ready_in,
    input  noc_pkg::flit_t router_data_in,
    input  logic           router_valid_in,
    output logic           gpu_ready_out,
    output noc_pkg::flit_t gpu_data_out,
    output logic           gpu_valid_out,
    output noc_pkg::flit_t router_data_out,
    output logic           router_valid_out
);
    import noc_pkg::*;

    localparam route_addr_t MY_ADDR = gpu_to_addr(GPU_ID);

    gpu_id_t     tx_id;
    flit_t       tx_flit;
    flit_t       tx_head;
    logic        tx_push;
    logic        tx_pop;
    logic        tx_full;
    logic        tx_empty;

    route_addr_t rx_hdr;
    logic        rx_match;
    flit_t       rx_flit;
    flit_t       rx_head;
    logic        rx_push;
    logic        rx_pop;
    logic        rx_full;
    logic        rx_empty;

    // GPU to router swaps the destination ID for its routing address
    assign tx_id         = flit_hdr(gpu_data_in);
    assign tx_flit       = {gpu_to_addr(tx_id), flit_payload(gpu_data_in)};
    assign tx_push       = gpu_valid_in && !tx_full;
    assign tx_pop        = router_ready_in && !tx_empty;
    assign gpu_ready_out = !tx_full;

    ni_fifo #(.DEPTH(NI_FIFO_DEPTH)) u_tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (tx_push),
        .push_data (tx_flit),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    // Router to GPU keeps only its own flits and drops them on a full queue
    assign rx_hdr   = flit_hdr(router_data_in);
    assign rx_match = router_valid_in && (rx_hdr == MY_ADDR);
    assign rx_push  = rx_match && !rx_full;
    assign rx_flit  = {addr_to_gpu(rx_hdr), flit_payload(router_data_in)};
    assign rx_pop   = gpu_ready_in && !rx_empty;

    ni_fifo #(.DEPTH(NI_FIFO_DEPTH)) u_rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_push),
        .push_data (rx_flit),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            router_valid_out <= 1'b0;
            gpu_valid_out    <= 1'b0;
        end else begin
            router_valid_out <= tx_pop;
            gpu_valid_out    <= rx_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_pop) begin
            router_data_out <= tx_head;
        end
        if (rx_pop) begin
            gpu_data_out <= rx_head;
        end
    end

    // Delivered flits carry this GPU's own ID
    a_rx_own_id: assert property (@(posedge clk) disable iff (reset)
        gpu_valid_out |-> (flit_hdr(gpu_data_out) == GPU_ID));

endmodule

// File: verilog/ni_fifo.sv
`timescale 1ns/1ps

module ni_fifo #(
    parameter int DEPTH = noc_pkg::NI_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           push,
    input  noc_pkg::flit_t push_data,
    input  logic           pop,
    output noc_pkg::flit_t pop_data,
    output logic           full,
    output logic           empty
);
    import noc_pkg::*;

    // DEPTH is a power of two, so the pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign wr_en    = push && !full;
    assign rd_en    = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

// File: verilog/noc_pkg.sv
package noc_pkg;

    localparam int FLIT_W    = 16;
    localparam int GROUP_W   = 4;
    localparam int LEAF_W    = 2;
    localparam int HDR_W     = GROUP_W + LEAF_W;
    localparam int PAYLOAD_W = FLIT_W - HDR_W;

    typedef logic [FLIT_W-1:0]    flit_t;
    typedef logic [HDR_W-1:0]     gpu_id_t;
    typedef logic [HDR_W-1:0]     route_addr_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [GROUP_W-1:0]   group_t;
    typedef logic [LEAF_W-1:0]    leaf_t;

    localparam int     NUM_LEAVES    = 4;
    localparam group_t CLUSTER_GROUP = 4'd3;
    localparam int     NI_FIFO_DEPTH = 4;
    localparam int     ADDR_OFFSET   = 3;
    localparam int     MAX_GPU_ID    = 32;

    function automatic route_addr_t flit_hdr(input flit_t f);
        return f[FLIT_W-1 -: HDR_W];
    endfunction

    function automatic payload_t flit_payload(input flit_t f);
        return f[PAYLOAD_W-1:0];
    endfunction

    function automatic group_t addr_group(input route_addr_t a);
        return a[HDR_W-1 -: GROUP_W];
    endfunction

    // IDs 1..32 map to address ID + 3, anything else to 0
    function automatic route_addr_t gpu_to_addr(input gpu_id_t id);
        int addr;
        addr = int'(id) + ADDR_OFFSET;
        if (int'(id) < 1 || int'(id) > MAX_GPU_ID) begin
            addr = 0;
        end
        return route_addr_t'(addr);
    endfunction

    // Inverse of gpu_to_addr where unknown addresses give ID 0
    function automatic gpu_id_t addr_to_gpu(input route_addr_t addr);
        int id;
        id = int'(addr) - ADDR_OFFSET;
        if (id < 1 || id > MAX_GPU_ID) begin
            id = 0;
        end
        return gpu_id_t'(id);
    endfunction

endpackage
